//--- hw/pwm_defines.svh
/*
 * Build-time sizes and register addresses of the multichannel PWM generator.
 * Include this header in any file that sizes ports or decodes bus addresses.
 */
`ifndef PWM_DEFINES_SVH
`define PWM_DEFINES_SVH

// Number of complementary pin pairs
`define PWM_N_CHANNELS 3

// Counter and threshold width
`define PWM_COUNTER_WIDTH 16

// Dead-time and start-delay width
`define PWM_DEADTIME_WIDTH 8

// Bus address width and register map, starting at zero
`define PWM_ADDR_WIDTH 4
`define PWM_ADDR_CONTROL 0
`define PWM_ADDR_PERIOD 1
`define PWM_ADDR_SHIFT 2
`define PWM_ADDR_CHANNEL_BASE 4

`endif

//--- hw/pwm_timing_pkg.sv
/*
 * Timing enumerations shared by the run control, the counter and the
 * register file: the counter mode and the run-control states.
 */
package pwm_timing_pkg;

    // Counter modes as stored in the control register
    typedef enum logic [1:0] {
        MODE_UP      = 2'd0,
        MODE_UP_DOWN = 2'd1,
        MODE_OFF     = 2'd2
    } counter_mode_e;

    // Run-control FSM states
    typedef enum logic [1:0] {
        RUN_IDLE     = 2'd0,
        RUN_DELAYING = 2'd1,
        RUN_RUNNING  = 2'd2
    } run_state_e;

endpackage

//--- hw/pwm_reg_pkg.sv
/*
 * Register-map types of the PWM generator. A bus write word is decoded
 * either as the control word or as a channel's threshold pair.
 */
`include "pwm_defines.svh"

package pwm_reg_pkg;

    // Control register, run bit in the top bit
    typedef struct packed {
        logic                               run;
        pwm_timing_pkg::counter_mode_e      counter_mode;
        logic                               deadtime_enable;
        logic [`PWM_N_CHANNELS-1:0]         output_enable;
        logic [`PWM_DEADTIME_WIDTH-1:0]     deadtime;
        logic [27-`PWM_N_CHANNELS-`PWM_DEADTIME_WIDTH:0] padding;
    } control_word_s;

    // Channel window, low threshold in the upper half
    typedef struct packed {
        logic [`PWM_COUNTER_WIDTH-1:0] low;
        logic [`PWM_COUNTER_WIDTH-1:0] high;
    } threshold_pair_s;

    typedef union packed {
        control_word_s   control;
        threshold_pair_s pair;
    } reg_word_u;

endpackage

//--- hw/pwm_cfg_if.sv
/*
 * Configuration bundle from the register file to the PWM datapath.
 * The register file drives it through source; run control, counter and
 * channels read it through sink.
 */
`include "pwm_defines.svh"

interface pwm_cfg_if;
    import pwm_reg_pkg::*;
    import pwm_timing_pkg::*;

    logic                           run;
    counter_mode_e                  counter_mode;
    logic [`PWM_COUNTER_WIDTH-1:0]  period;
    logic [`PWM_DEADTIME_WIDTH-1:0] timebase_shift;
    threshold_pair_s                thresholds [`PWM_N_CHANNELS];
    logic [`PWM_N_CHANNELS-1:0]     output_enable;
    logic                           deadtime_enable;
    logic [`PWM_DEADTIME_WIDTH-1:0] deadtime;

    modport source (
        output run, counter_mode, period, timebase_shift,
        output thresholds, output_enable, deadtime_enable, deadtime
    );

    modport sink (
        input run, counter_mode, period, timebase_shift,
        input thresholds, output_enable, deadtime_enable, deadtime
    );

endinterface

//--- hw/pwm_register_file.sv
/*
 * Four-phase req/ack bus slave holding the PWM configuration registers.
 * Each request is answered once; a write lands on the edge where bus_ack
 * rises and read data stays valid while bus_ack is high.
 */
`include "pwm_defines.svh"

module pwm_register_file (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       bus_req,
    input  logic                       bus_write,
    input  logic [`PWM_ADDR_WIDTH-1:0] bus_address,
    input  logic [31:0]                bus_write_data,
    output logic                       bus_ack,
    output logic [31:0]                bus_read_data,
    pwm_cfg_if.source                  cfg
);
    import pwm_reg_pkg::*;
    import pwm_timing_pkg::*;

    typedef enum logic {BUS_IDLE, BUS_ACK} bus_state_e;

    bus_state_e state;
    reg_word_u  write_word;
    reg_word_u  read_word;

    assign write_word = bus_write_data;
    assign bus_ack = (state == BUS_ACK);

    // Read mux builds the stored word for the requested address
    always_comb begin
        read_word = '0;
        case (bus_address)
            `PWM_ADDR_CONTROL: begin
                read_word.control.run = cfg.run;
                read_word.control.counter_mode = cfg.counter_mode;
                read_word.control.deadtime_enable = cfg.deadtime_enable;
                read_word.control.output_enable = cfg.output_enable;
                read_word.control.deadtime = cfg.deadtime;
            end
            `PWM_ADDR_PERIOD: read_word[`PWM_COUNTER_WIDTH-1:0] = cfg.period;
            `PWM_ADDR_SHIFT: read_word[`PWM_DEADTIME_WIDTH-1:0] = cfg.timebase_shift;
            default: begin
                for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                    if (int'(bus_address) == `PWM_ADDR_CHANNEL_BASE + i) begin
                        read_word.pair = cfg.thresholds[i];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= BUS_IDLE;
            cfg.run <= 1'b0;
            cfg.counter_mode <= MODE_OFF;
            cfg.period <= '0;
            cfg.timebase_shift <= '0;
            cfg.output_enable <= '0;
            cfg.deadtime_enable <= 1'b0;
            cfg.deadtime <= '0;
            for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                cfg.thresholds[i] <= '0;
            end
        end else if (state == BUS_IDLE) begin
            if (bus_req) begin
                state <= BUS_ACK;
                bus_read_data <= read_word;
                if (bus_write) begin
                    case (bus_address)
                        `PWM_ADDR_CONTROL: begin
                            cfg.run <= write_word.control.run;
                            cfg.counter_mode <= write_word.control.counter_mode;
                            cfg.deadtime_enable <= write_word.control.deadtime_enable;
                            cfg.output_enable <= write_word.control.output_enable;
                            cfg.deadtime <= write_word.control.deadtime;
                        end
                        `PWM_ADDR_PERIOD: cfg.period <= bus_write_data[`PWM_COUNTER_WIDTH-1:0];
                        `PWM_ADDR_SHIFT: begin
                            cfg.timebase_shift <= bus_write_data[`PWM_DEADTIME_WIDTH-1:0];
                        end
                        default: begin
                            for (int i = 0; i < `PWM_N_CHANNELS; i++) begin
                                if (int'(bus_address) == `PWM_ADDR_CHANNEL_BASE + i) begin
                                    cfg.thresholds[i] <= write_word.pair;
                                end
                            end
                        end
                    endcase
                end
            end
        end else if (!bus_req) begin
            // Master has released the request, so the ack can fall
            state <= BUS_IDLE;
        end
    end

endmodule

//--- hw/pwm_run_control.sv
/*
 * Run-control FSM. Holds off the counter for the programmed start delay
 * after the run bit is set and stops it on a run clear or a stop request.
 */
`include "pwm_defines.svh"

module pwm_run_control (
    input  logic      clock,
    input  logic      reset,
    input  logic      stop_request,
    pwm_cfg_if.sink   cfg,
    output logic      counter_enable,
    output logic      counter_running
);
    import pwm_timing_pkg::*;

    run_state_e                     state;
    logic [`PWM_DEADTIME_WIDTH-1:0] delay_count;

    assign counter_enable = (state == RUN_RUNNING);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= RUN_IDLE;
            delay_count <= '0;
            counter_running <= 1'b0;
        end else begin
            // Status flag lags the enable by one clock
            counter_running <= (state == RUN_RUNNING);
            if (!cfg.run || stop_request) begin
                state <= RUN_IDLE;
            end else begin
                case (state)
                    RUN_IDLE: begin
                        delay_count <= cfg.timebase_shift;
                        if (cfg.timebase_shift == '0) begin
                            state <= RUN_RUNNING;
                        end else begin
                            state <= RUN_DELAYING;
                        end
                    end
                    RUN_DELAYING: begin
                        delay_count <= delay_count - 1'b1;
                        // The last delay clock is the one that takes the count to zero
                        if (delay_count == 1) begin
                            state <= RUN_RUNNING;
                        end
                    end
                    default: state <= RUN_RUNNING;
                endcase
            end
        end
    end

endmodule

//--- hw/pwm_counter.sv
/*
 * Shared PWM period counter. Up mode runs 0 to period-1, up-down mode
 * runs 0 up to period and back down to 1. The reload flag marks count
 * zero so the channels can take new thresholds between periods.
 */
`include "pwm_defines.svh"

module pwm_counter (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          counter_enable,
    pwm_cfg_if.sink                       cfg,
    output logic [`PWM_COUNTER_WIDTH-1:0] count,
    output logic                          reload
);
    import pwm_timing_pkg::*;

    logic                          counting_down;
    logic [`PWM_COUNTER_WIDTH:0]   count_next_up;

    // One bit wider so that a period of zero or full scale still compares cleanly
    assign count_next_up = count + 1'b1;
    assign reload = (count == '0);

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            counting_down <= 1'b0;
        end else if (!counter_enable || cfg.counter_mode == MODE_OFF) begin
            count <= '0;
            counting_down <= 1'b0;
        end else if (cfg.counter_mode == MODE_UP) begin
            counting_down <= 1'b0;
            if (count_next_up >= cfg.period) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end else if (!counting_down) begin
            // Up-down mode, rising half
            if (count_next_up >= cfg.period) begin
                counting_down <= 1'b1;
            end
            count <= count + 1'b1;
        end else begin
            // Falling half turns round after reaching one
            if (count == 1) begin
                counting_down <= 1'b0;
            end
            count <= count - 1'b1;
        end
    end

endmodule

//--- hw/pwm_channel.sv
/*
 * One PWM channel. Compares the shared count against a shadowed threshold
 * window and drives a complementary pin pair, delaying each pin's rising
 * edge by the dead time. Pins are registered.
 */
`include "pwm_defines.svh"

module pwm_channel #(
    parameter int CHANNEL = 0
) (
    input  logic                          clock,
    input  logic                          reset,
    pwm_cfg_if.sink                       cfg,
    input  logic [`PWM_COUNTER_WIDTH-1:0] count,
    input  logic                          reload,
    input  logic                          counter_running,
    output logic                          out_a,
    output logic                          out_b
);
    import pwm_reg_pkg::*;

    threshold_pair_s                shadow;
    logic                           active;
    logic                           in_window;
    logic [1:0]                     level;
    logic [1:0]                     pin;
    logic [`PWM_DEADTIME_WIDTH-1:0] dead_count [2];

    // Thresholds only change between periods or while stopped
    always_ff @(posedge clock) begin
        if (reload || !counter_running) begin
            shadow <= cfg.thresholds[CHANNEL];
        end
    end

    assign active = counter_running && cfg.output_enable[CHANNEL];
    assign in_window = (count >= shadow.low) && (count < shadow.high);

    // Index 0 is the A pin, index 1 its complement
    assign level[0] = active && in_window;
    assign level[1] = active && !in_window;

    always_ff @(posedge clock) begin
        if (!reset) begin
            pin <= '0;
            for (int p = 0; p < 2; p++) begin
                dead_count[p] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (!level[p]) begin
                    // Arm the delay for the next rising edge
                    pin[p] <= 1'b0;
                    dead_count[p] <= cfg.deadtime_enable ? cfg.deadtime : '0;
                end else if (dead_count[p] == '0) begin
                    pin[p] <= 1'b1;
                end else begin
                    dead_count[p] <= dead_count[p] - 1'b1;
                end
            end
        end
    end

    assign out_a = pin[0];
    assign out_b = pin[1];

endmodule

//--- hw/pwm_chain.sv
/*
 * Top level of the multichannel PWM generator. Connects the bus register
 * file, run control, shared counter and one channel per pin pair.
 */
`include "pwm_defines.svh"

module pwm_chain (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       stop_request,
    input  logic                       bus_req,
    input  logic                       bus_write,
    input  logic [`PWM_ADDR_WIDTH-1:0] bus_address,
    input  logic [31:0]                bus_write_data,
    output logic                       bus_ack,
    output logic [31:0]                bus_read_data,
    output logic                       counter_status,
    output logic [`PWM_N_CHANNELS-1:0] out_a,
    output logic [`PWM_N_CHANNELS-1:0] out_b
);

    logic                          counter_enable;
    logic                          counter_running;
    logic [`PWM_COUNTER_WIDTH-1:0] count;
    logic                          reload;

    pwm_cfg_if cfg ();

    assign counter_status = counter_running;

    pwm_register_file i_register_file (
        .clock(clock), .reset(reset),
        .bus_req(bus_req), .bus_write(bus_write), .bus_address(bus_address),
        .bus_write_data(bus_write_data), .bus_ack(bus_ack),
        .bus_read_data(bus_read_data), .cfg(cfg.source)
    );

    pwm_run_control i_run_control (
        .clock(clock), .reset(reset), .stop_request(stop_request), .cfg(cfg.sink),
        .counter_enable(counter_enable), .counter_running(counter_running)
    );

    pwm_counter i_counter (
        .clock(clock), .reset(reset), .counter_enable(counter_enable), .cfg(cfg.sink),
        .count(count), .reload(reload)
    );

    for (genvar i = 0; i < `PWM_N_CHANNELS; i++) begin : g_channel
        pwm_channel #(.CHANNEL(i)) i_channel (
            .clock(clock), .reset(reset), .cfg(cfg.sink),
            .count(count), .reload(reload), .counter_running(counter_running),
            .out_a(out_a[i]), .out_b(out_b[i])
        );
    end

endmodule

//--- bench/pwm_chain_asserts.sv
/*
 * Concurrent checks bound into the PWM top level. They watch the order of
 * the four-phase bus handshake and the non-overlap of each pin pair.
 */
`include "pwm_defines.svh"

module pwm_chain_asserts (
    input logic                       clock,
    input logic                       reset,
    input logic                       bus_req,
    input logic                       bus_ack,
    input logic [`PWM_N_CHANNELS-1:0] out_a,
    input logic [`PWM_N_CHANNELS-1:0] out_b
);

    // The slave only answers a request it has already seen
    ack_follows_req: assert property (@(posedge clock) disable iff (!reset)
        $rose(bus_ack) |-> $past(bus_req))
        else $error("bus_ack rose without a pending bus_req");

    ack_falls_after_release: assert property (@(posedge clock) disable iff (!reset)
        $fell(bus_ack) |-> !$past(bus_req))
        else $error("bus_ack fell while bus_req was still high");

    // Complementary pins of one channel must never conduct together
    pins_never_overlap: assert property (@(posedge clock) disable iff (!reset)
        (out_a & out_b) == '0)
        else $error("out_a and out_b of one channel are high together");

endmodule

//--- bench/pwm_chain_tb.sv
/*
 * Testbench for the multichannel PWM generator. Applies a table of counter
 * and channel settings over the four-phase bus, then checks register
 * readback, start delay, duty counts, threshold shadowing and stop.
 */
`include "pwm_defines.svh"

module pwm_chain_tb;
    import pwm_reg_pkg::*;
    import pwm_timing_pkg::*;

    localparam int N_ROWS = 7;
    localparam int N_CH = `PWM_N_CHANNELS;
    localparam int CLOCK_PERIOD = 100;
    localparam int WAIT_LIMIT = 1000;

    // One test case, expected high cycles per counter period per pin
    typedef struct packed {
        logic [1:0]                                 mode;
        logic [`PWM_COUNTER_WIDTH-1:0]              period;
        logic [`PWM_DEADTIME_WIDTH-1:0]             shift;
        logic                                       dt_en;
        logic [`PWM_DEADTIME_WIDTH-1:0]             dt;
        logic [N_CH-1:0]                            oe;
        logic [N_CH-1:0][`PWM_COUNTER_WIDTH-1:0]    low;
        logic [N_CH-1:0][`PWM_COUNTER_WIDTH-1:0]    high;
        logic [N_CH-1:0][`PWM_COUNTER_WIDTH-1:0]    exp_a;
        logic [N_CH-1:0][`PWM_COUNTER_WIDTH-1:0]    exp_b;
    } row_s;

    logic                       clock;
    logic                       reset;
    logic                       stop_request;
    logic                       bus_req;
    logic                       bus_write;
    logic [`PWM_ADDR_WIDTH-1:0] bus_address;
    logic [31:0]                bus_write_data;
    logic                       bus_ack;
    logic [31:0]                bus_read_data;
    logic                       counter_status;
    logic [N_CH-1:0]            out_a;
    logic [N_CH-1:0]            out_b;

    row_s   table_rows [N_ROWS];
    int     high_a [N_CH];
    int     high_b [N_CH];
    int     errors = 0;
    int     checks = 0;
    int     cycle = 0;
    int     ack_cycle = 0;
    int     wd_cycles = 0;
    bit     table_ready = 1'b0;
    integer seed = 32'h145c4b5f;

    pwm_chain i_pwm_chain (
        .clock(clock), .reset(reset), .stop_request(stop_request),
        .bus_req(bus_req), .bus_write(bus_write), .bus_address(bus_address),
        .bus_write_data(bus_write_data), .bus_ack(bus_ack), .bus_read_data(bus_read_data),
        .counter_status(counter_status), .out_a(out_a), .out_b(out_b)
    );

    bind pwm_chain pwm_chain_asserts i_asserts (
        .clock(clock), .reset(reset), .bus_req(bus_req), .bus_ack(bus_ack),
        .out_a(out_a), .out_b(out_b)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    function automatic int clamp_zero(input int value);
        return (value < 0) ? 0 : value;
    endfunction

    // High cycles of one pin per counter period; a pin loses dt on each rising edge
    function automatic int expected_width(input logic [1:0] mode, input int period,
                                          input int low, input int high, input int dt,
                                          input bit complement);
        int window;
        window = high - low;
        if (mode == MODE_UP) begin
            if (!complement) begin
                return clamp_zero(window - dt);
            end else begin
                return clamp_zero(period - window - dt);
            end
        end else if (!complement) begin
            return 2 * clamp_zero(window - dt);
        end else begin
            // Complement splits into a run around zero and a run around the peak
            return clamp_zero(2 * low - 1 - dt) + clamp_zero(2 * (period - high) + 1 - dt);
        end
    endfunction

    function automatic int period_length(input row_s row);
        return (row.mode == MODE_UP_DOWN) ? 2 * row.period : row.period;
    endfunction

    function automatic logic [31:0] control_word(input logic run, input logic [1:0] mode,
                                                 input logic dt_en, input logic [N_CH-1:0] oe,
                                                 input logic [`PWM_DEADTIME_WIDTH-1:0] dt);
        control_word_s word;
        word = '0;
        word.run = run;
        word.counter_mode = counter_mode_e'(mode);
        word.deadtime_enable = dt_en;
        word.output_enable = oe;
        word.deadtime = dt;
        return word;
    endfunction

    function automatic logic [31:0] pair_word(input int low, input int high);
        threshold_pair_s pair;
        pair.low = low;
        pair.high = high;
        return pair;
    endfunction

    task automatic set_row(input int idx, input logic [1:0] mode, input int period,
                           input int shift, input logic dt_en, input int dt,
                           input logic [N_CH-1:0] oe, input int l0, input int h0,
                           input int l1, input int h1, input int l2, input int h2);
        int lows [3];
        int highs [3];
        int eff_dt;
        lows = '{l0, l1, l2};
        highs = '{h0, h1, h2};
        eff_dt = dt_en ? dt : 0;
        table_rows[idx].mode = mode;
        table_rows[idx].period = period;
        table_rows[idx].shift = shift;
        table_rows[idx].dt_en = dt_en;
        table_rows[idx].dt = dt;
        table_rows[idx].oe = oe;
        for (int ch = 0; ch < N_CH; ch++) begin
            table_rows[idx].low[ch] = lows[ch];
            table_rows[idx].high[ch] = highs[ch];
            table_rows[idx].exp_a[ch] = oe[ch] ?
                expected_width(mode, period, lows[ch], highs[ch], eff_dt, 1'b0) : 0;
            table_rows[idx].exp_b[ch] = oe[ch] ?
                expected_width(mode, period, lows[ch], highs[ch], eff_dt, 1'b1) : 0;
        end
    endtask

    // Windows stay within 1 <= low < high <= period
    task automatic make_random_row(input int idx, input logic [1:0] mode);
        int period;
        int lows [3];
        int highs [3];
        period = 8 + {$random(seed)} % 40;
        for (int ch = 0; ch < 3; ch++) begin
            lows[ch] = 1 + {$random(seed)} % (period / 2);
            highs[ch] = lows[ch] + 1 + {$random(seed)} % (period - lows[ch]);
        end
        set_row(idx, mode, period, {$random(seed)} % 8, 1'b1, {$random(seed)} % 4, '1,
                lows[0], highs[0], lows[1], highs[1], lows[2], highs[2]);
    endtask

    // Inputs change and outputs are sampled a fixed delay after each rising edge
    task automatic step_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %0d, actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic bus_transfer(input logic write, input logic [`PWM_ADDR_WIDTH-1:0] address,
                                input logic [31:0] data, output logic [31:0] read_data);
        int waited;
        step_cycle();
        bus_req = 1'b1;
        bus_write = write;
        bus_address = address;
        bus_write_data = data;
        waited = 0;
        while (!bus_ack && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (!bus_ack) begin
            errors++;
            $display("Error at time %0t: no bus_ack for a request to address %0d",
                     $time, address);
        end
        ack_cycle = cycle;
        read_data = bus_read_data;
        bus_req = 1'b0;
        waited = 0;
        while (bus_ack && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (bus_ack) begin
            errors++;
            $display("Error at time %0t: bus_ack stayed high after bus_req dropped", $time);
        end
    endtask

    task automatic write_checked(input logic [`PWM_ADDR_WIDTH-1:0] address,
                                 input logic [31:0] data);
        logic [31:0] read_data;
        bus_transfer(1'b1, address, data, read_data);
        bus_transfer(1'b0, address, '0, read_data);
        check_value($sformatf("register %0d readback", address), data, read_data);
    endtask

    task automatic wait_status(input logic level);
        int waited;
        waited = 0;
        while (counter_status !== level && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (counter_status !== level) begin
            errors++;
            $display("Error at time %0t: counter_status never went to %b", $time, level);
        end
    endtask

    task automatic wait_pin_a(input int ch, input logic level);
        int waited;
        waited = 0;
        while (out_a[ch] !== level && waited < WAIT_LIMIT) begin
            step_cycle();
            waited++;
        end
        if (out_a[ch] !== level) begin
            errors++;
            $display("Error at time %0t: out_a[%0d] never went to %b", $time, ch, level);
        end
    endtask

    task automatic measure_pulse(input int ch, output int width);
        width = 0;
        while (out_a[ch] === 1'b1 && width < WAIT_LIMIT) begin
            width++;
            step_cycle();
        end
    endtask

    task automatic count_high(input int cycles);
        for (int ch = 0; ch < N_CH; ch++) begin
            high_a[ch] = 0;
            high_b[ch] = 0;
        end
        repeat (cycles) begin
            step_cycle();
            for (int ch = 0; ch < N_CH; ch++) begin
                high_a[ch] += out_a[ch];
                high_b[ch] += out_b[ch];
            end
        end
    endtask

    task automatic run_row(input int r);
        row_s        row;
        logic [31:0] read_data;
        logic [31:0] word;
        int          lp;
        row = table_rows[r];
        lp = period_length(row);
        word = control_word(1'b1, row.mode, row.dt_en, row.oe, row.dt);
        write_checked(`PWM_ADDR_CONTROL, word & 32'h7fff_ffff);
        write_checked(`PWM_ADDR_PERIOD, row.period);
        write_checked(`PWM_ADDR_SHIFT, row.shift);
        for (int ch = 0; ch < N_CH; ch++) begin
            write_checked(`PWM_ADDR_CHANNEL_BASE + ch, pair_word(row.low[ch], row.high[ch]));
        end
        // Start delay counts from the edge where the run write is acknowledged
        bus_transfer(1'b1, `PWM_ADDR_CONTROL, word, read_data);
        wait_status(1'b1);
        check_value($sformatf("row %0d start delay", r), row.shift + 2, cycle - ack_cycle);
        bus_transfer(1'b0, `PWM_ADDR_CONTROL, '0, read_data);
        check_value("control readback while running", word, read_data);
        repeat (2 * lp) step_cycle();
        count_high(lp);
        for (int ch = 0; ch < N_CH; ch++) begin
            check_value($sformatf("row %0d out_a[%0d] high cycles", r, ch),
                        row.exp_a[ch], high_a[ch]);
            check_value($sformatf("row %0d out_b[%0d] high cycles", r, ch),
                        row.exp_b[ch], high_b[ch]);
        end
    endtask

    // New window lands mid-pulse and must wait for the next reload
    task automatic check_shadowing();
        logic [31:0] read_data;
        int          width;
        write_checked(`PWM_ADDR_CONTROL, control_word(1'b0, MODE_UP, 1'b0, 1, 0));
        write_checked(`PWM_ADDR_PERIOD, 40);
        write_checked(`PWM_ADDR_SHIFT, 0);
        write_checked(`PWM_ADDR_CHANNEL_BASE, pair_word(10, 30));
        bus_transfer(1'b1, `PWM_ADDR_CONTROL, control_word(1'b1, MODE_UP, 1'b0, 1, 0),
                     read_data);
        wait_status(1'b1);
        repeat (80) step_cycle();
        wait_pin_a(0, 1'b0);
        wait_pin_a(0, 1'b1);
        fork
            measure_pulse(0, width);
            bus_transfer(1'b1, `PWM_ADDR_CHANNEL_BASE, pair_word(5, 15), read_data);
        join
        check_value("out_a[0] width before reload", 30 - 10, width);
        wait_pin_a(0, 1'b1);
        measure_pulse(0, width);
        check_value("out_a[0] width after reload", 15 - 5, width);
    endtask

    task automatic check_stop();
        int waited;
        stop_request = 1'b1;
        waited = 0;
        while ((counter_status || out_a != '0 || out_b != '0) && waited < 10) begin
            step_cycle();
            waited++;
        end
        repeat (20) begin
            step_cycle();
            check_value("counter_status under stop", 0, counter_status);
            check_value("out_a under stop", 0, out_a);
            check_value("out_b under stop", 0, out_b);
        end
        stop_request = 1'b0;
    endtask

    initial begin : watchdog
        wait (table_ready);
        #(wd_cycles * CLOCK_PERIOD);
        $display("Error at time %0t: timeout, the run did not end within %0d cycles",
                 $time, wd_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        int total_lp;
        reset = 1'b0;
        stop_request = 1'b0;
        bus_req = 1'b0;
        bus_write = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        set_row(0, MODE_UP, 20, 3, 1'b0, 0, 3'b111, 5, 15, 0, 10, 10, 19);
        set_row(1, MODE_UP, 30, 0, 1'b1, 2, 3'b111, 4, 20, 10, 25, 1, 3);
        set_row(2, MODE_UP_DOWN, 16, 5, 1'b1, 1, 3'b111, 4, 12, 1, 8, 6, 16);
        set_row(3, MODE_UP, 25, 1, 1'b1, 3, 3'b101, 5, 20, 5, 20, 2, 12);
        set_row(4, MODE_UP_DOWN, 12, 2, 1'b0, 0, 3'b010, 2, 6, 3, 9, 4, 12);
        make_random_row(5, MODE_UP);
        make_random_row(6, MODE_UP_DOWN);
        total_lp = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total_lp += period_length(table_rows[r]);
        end
        wd_cycles = N_ROWS * total_lp * 4 + 5000;
        table_ready = 1'b1;
        repeat (8) @(posedge clock);
        #10;
        reset = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        check_shadowing();
        check_stop();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- pwm_chain.f
+incdir+hw
hw/pwm_timing_pkg.sv
hw/pwm_reg_pkg.sv
hw/pwm_cfg_if.sv
hw/pwm_register_file.sv
hw/pwm_run_control.sv
hw/pwm_counter.sv
hw/pwm_channel.sv
hw/pwm_chain.sv
bench/pwm_chain_asserts.sv
bench/pwm_chain_tb.sv

//--- Bender.yml
package:
  name: pwm_chain

sources:
  - include_dirs:
      - hw
    files:
      - hw/pwm_timing_pkg.sv
      - hw/pwm_reg_pkg.sv
      - hw/pwm_cfg_if.sv
      - hw/pwm_register_file.sv
      - hw/pwm_run_control.sv
      - hw/pwm_counter.sv
      - hw/pwm_channel.sv
      - hw/pwm_chain.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/pwm_chain_asserts.sv
      - bench/pwm_chain_tb.sv
